// ==== verilog/mem_pkg.sv ====
// Shared definitions for the game memory side
// Region map, slot numbering, arbiter states and the bus structs
// used between the client slots, the arbiter and the SDRAM

package mem_pkg;

    localparam int SLOT_N = 4;
    localparam int SLOT_W = 2;

    // Lower index wins arbitration
    localparam int SLOT_MAIN_ROM = 0;
    localparam int SLOT_MAIN_RAM = 1;
    localparam int SLOT_GFX      = 2;
    localparam int SLOT_SND      = 3;

    // SDRAM word addresses of each region
    localparam logic [21:0] ROM_OFFSET = 22'h00_0000;
    localparam logic [21:0] RAM_OFFSET = 22'h10_0000;
    localparam logic [21:0] GFX_OFFSET = 22'h18_0000;
    localparam logic [21:0] SND_OFFSET = 22'h08_0000;

    // Download bytes from here up are board configuration
    localparam logic [22:0] CFG_START = 23'h60_0000;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

    typedef struct packed {
        logic        cs;
        logic        wr;
        logic [21:0] addr;
        logic [15:0] din;
        logic [1:0]  wrmask;
    } slot_req_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } slot_rsp_t;

    typedef struct packed {
        logic [21:0] addr;
        logic        rnw;
        logic [1:0]  wrmask;
        logic [15:0] din;
    } sdram_cmd_t;

    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;
    } prog_cmd_t;

    // Region base for a slot index
    function automatic logic [21:0] slot_offset(input int slot);
        case (slot)
            SLOT_MAIN_ROM: return ROM_OFFSET;
            SLOT_MAIN_RAM: return RAM_OFFSET;
            SLOT_GFX:      return GFX_OFFSET;
            SLOT_SND:      return SND_OFFSET;
            default:       return ROM_OFFSET;
        endcase
    endfunction

endpackage

// ==== verilog/slot_port.sv ====
// Client slot port
// Adds the region offset, keeps the last read word as a one-entry
// cache and raises pending towards the arbiter on a miss or a write

module slot_port #(
    parameter logic [21:0] OFFSET   = 22'd0,
    parameter bit          WRITABLE = 1'b0
) (
    input  logic                VB,
    input  logic                rst_n,
    input  mem_pkg::slot_req_t  req,
    output mem_pkg::slot_rsp_t  rsp,
    output logic                pending,
    output mem_pkg::sdram_cmd_t cmd,
    input  logic                done,
    input  logic [15:0]         rd_data
);

    logic        wr_en;
    logic        hit;
    logic        changed;
    logic        need_access;
    logic        ok;
    logic [21:0] addr_q;
    logic        cache_valid;
    logic [21:0] cache_addr;
    logic [15:0] cache_data;
    logic [21:0] pend_addr;
    logic        pend_wr;
    logic [15:0] pend_din;
    logic [1:0]  pend_mask;
    logic [15:0] merged;

    // Writes on a read-only slot are treated as reads
    assign wr_en   = WRITABLE && req.wr;
    assign hit     = req.cs && !wr_en && cache_valid && (req.addr == cache_addr);
    assign changed = req.addr != addr_q;

    // A write already answered at this address needs no new access
    assign need_access = req.cs && (wr_en ? !(ok && !changed) : !hit);

    // Active-low byte mask, masked lanes keep the cached byte
    assign merged = {pend_mask[1] ? cache_data[15:8] : pend_din[15:8],
                     pend_mask[0] ? cache_data[7:0]  : pend_din[7:0]};

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            ok      <= 1'b0;
            pending <= 1'b0;
        end else begin
            ok <= (done && req.cs) || hit || (req.cs && ok && !changed);
            if (done) begin
                pending <= 1'b0;
            end else if (need_access) begin
                pending <= 1'b1;
            end
        end
    end

    // Request captured when pending rises, held for the arbiter
    always_ff @(posedge VB) begin
        addr_q <= req.addr;
        if (!pending && need_access) begin
            pend_addr <= req.addr;
            pend_wr   <= wr_en;
            pend_din  <= req.din;
            pend_mask <= req.wrmask;
        end
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
        end else if (done && !pend_wr) begin
            cache_valid <= 1'b1;
        end
    end

    always_ff @(posedge VB) begin
        if (done) begin
            if (!pend_wr) begin
                cache_addr <= pend_addr;
                cache_data <= rd_data;
            end else if (cache_valid && cache_addr == pend_addr) begin
                cache_data <= merged;
            end
        end
    end

    assign cmd.addr   = OFFSET + pend_addr;
    assign cmd.rnw    = !pend_wr;
    assign cmd.wrmask = pend_wr ? pend_mask : 2'b11;
    assign cmd.din    = pend_din;

    assign rsp.ok   = ok;
    assign rsp.data = cache_data;

endmodule

// ==== verilog/slot_arbiter.sv ====
// Fixed-priority SDRAM arbiter
// Grants the lowest pending slot, keeps one request in flight and
// reports completion back to the slot on data_rdy

module slot_arbiter (
    input  logic                VB,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic [3:0]          pending,
    input  mem_pkg::sdram_cmd_t cmds [mem_pkg::SLOT_N],
    output logic [3:0]          done,
    output logic [15:0]         rd_data,
    output logic                sdram_req,
    output mem_pkg::sdram_cmd_t sdram_cmd,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [15:0]         data_read,
    output logic                refresh_en
);

    mem_pkg::arb_state_e         state;
    logic [mem_pkg::SLOT_W-1:0]  gnt;
    logic [mem_pkg::SLOT_W-1:0]  sel;
    logic                        any_pend;
    mem_pkg::sdram_cmd_t         cmd_q;

    assign any_pend = |pending;

    // Scan from the top so the lowest index is left in sel
    always_comb begin
        sel = '0;
        for (int i = mem_pkg::SLOT_N - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel = i[mem_pkg::SLOT_W-1:0];
            end
        end
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            state <= mem_pkg::ARB_IDLE;
            gnt   <= '0;
        end else begin
            case (state)
                mem_pkg::ARB_IDLE: begin
                    if (any_pend && !downloading) begin
                        gnt   <= sel;
                        state <= mem_pkg::ARB_WAIT_ACK;
                    end
                end
                mem_pkg::ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= mem_pkg::ARB_WAIT_DATA;
                    end
                end
                mem_pkg::ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= mem_pkg::ARB_IDLE;
                    end
                end
                default: state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    // Command frozen at grant time
    always_ff @(posedge VB) begin
        if (state == mem_pkg::ARB_IDLE && any_pend && !downloading) begin
            cmd_q <= cmds[sel];
        end
    end

    assign sdram_req = state == mem_pkg::ARB_WAIT_ACK;
    assign sdram_cmd = cmd_q;

    always_comb begin
        done = '0;
        if (state == mem_pkg::ARB_WAIT_DATA && data_rdy) begin
            done[gnt] = 1'b1;
        end
    end

    assign rd_data = data_read;

    // Refresh only when nothing wants the bus
    assign refresh_en = state == mem_pkg::ARB_IDLE && !any_pend && !downloading;

endmodule

// ==== verilog/rom_loader.sv ====
// ROM download writer
// Turns loader byte writes into masked 16-bit SDRAM programming
// writes, or into configuration strobes above the SDRAM region

module rom_loader (
    input  logic               VB,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic [22:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    output mem_pkg::prog_cmd_t prog,
    output logic               prog_we,
    input  logic               sdram_ack,
    output logic               cfg_we
);

    logic is_cfg;
    logic wr_ok;

    assign is_cfg = ioctl_addr >= mem_pkg::CFG_START;
    assign wr_ok  = ioctl_wr && downloading;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            cfg_we  <= 1'b0;
        end else begin
            cfg_we <= wr_ok && is_cfg;
            if (wr_ok && !is_cfg) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Byte address halved into a word address, lane picked by bit 0
    always_ff @(posedge VB) begin
        if (wr_ok) begin
            prog.data <= ioctl_data;
            if (is_cfg) begin
                prog.mask <= 2'b11;
            end else begin
                prog.addr <= ioctl_addr[22:1];
                prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

// ==== verilog/cps_mem_top.sv ====
// Game memory top level
// Four client slots share one SDRAM through the arbiter, next to
// the ROM download writer

module cps_mem_top (
    input  logic                VB,
    input  logic                rst_n,
    input  mem_pkg::slot_req_t  slot_req [mem_pkg::SLOT_N],
    output mem_pkg::slot_rsp_t  slot_rsp [mem_pkg::SLOT_N],
    input  logic                downloading,
    input  logic [22:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    output mem_pkg::prog_cmd_t  prog,
    output logic                prog_we,
    output logic                cfg_we,
    output logic                sdram_req,
    output mem_pkg::sdram_cmd_t sdram_cmd,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [15:0]         data_read,
    output logic                refresh_en
);

    logic [mem_pkg::SLOT_N-1:0] pending;
    logic [mem_pkg::SLOT_N-1:0] done;
    logic [15:0]                rd_data;
    mem_pkg::sdram_cmd_t        cmds [mem_pkg::SLOT_N];

    // Only the work RAM slot accepts writes
    for (genvar i = 0; i < mem_pkg::SLOT_N; i++) begin : g_slot
        slot_port #(
            .OFFSET   (mem_pkg::slot_offset(i)),
            .WRITABLE (i == mem_pkg::SLOT_MAIN_RAM)
        ) u_slot (
            .VB      (VB),
            .rst_n   (rst_n),
            .req     (slot_req[i]),
            .rsp     (slot_rsp[i]),
            .pending (pending[i]),
            .cmd     (cmds[i]),
            .done    (done[i]),
            .rd_data (rd_data)
        );
    end

    slot_arbiter u_arbiter (
        .VB          (VB),
        .rst_n       (rst_n),
        .downloading (downloading),
        .pending     (pending),
        .cmds        (cmds),
        .done        (done),
        .rd_data     (rd_data),
        .sdram_req   (sdram_req),
        .sdram_cmd   (sdram_cmd),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .refresh_en  (refresh_en)
    );

    rom_loader u_loader (
        .VB          (VB),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog        (prog),
        .prog_we     (prog_we),
        .sdram_ack   (sdram_ack),
        .cfg_we      (cfg_we)
    );

endmodule

// ==== verif/tb_clk.sv ====
// Testbench clock and reset
// Free-running clock, reset held low for a few cycles after start

module tb_clk #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic VB,
    output logic rst_n
);

    initial begin
        VB    = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge VB);
        @(negedge VB);
        rst_n = 1'b1;
    end

    always #(PERIOD / 2) VB = ~VB;

endmodule

// ==== verif/lfsr.svh ====
// Galois LFSR used for SDRAM fill words
// A fill word is built from 16 LFSR steps, one bit per step, from a
// state seeded by the word address

localparam logic [31:0] LFSR_SEED = 32'd72159;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [15:0] fill_word(input logic [21:0] addr);
    logic [31:0] s;
    logic [15:0] w;
    s = LFSR_SEED ^ {10'd0, addr};
    // All-zero state would lock up
    if (s == 32'd0) begin
        s = LFSR_SEED;
    end
    for (int i = 0; i < 16; i++) begin
        s    = lfsr_step(s);
        w[i] = s[0];
    end
    return w;
endfunction

// ==== verif/sdram_model.sv ====
// Behavioral SDRAM
// Acks a request one cycle after it is seen, returns data_rdy LAT
// cycles after the ack; unwritten words read as LFSR fill

module sdram_model #(
    parameter int LAT = 3
) (
    input  logic                VB,
    input  logic                rst_n,
    input  logic                sdram_req,
    input  mem_pkg::sdram_cmd_t sdram_cmd,
    input  logic                prog_we,
    input  mem_pkg::prog_cmd_t  prog,
    output logic                sdram_ack,
    output logic                data_rdy,
    output logic [15:0]         data_read
);

    `include "lfsr.svh"

    logic [15:0]         mem [logic [21:0]];
    logic                busy;
    int                  cnt;
    mem_pkg::sdram_cmd_t cmd_q;

    function automatic logic [15:0] read_word(input logic [21:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    // Active-low lane mask
    task automatic write_word(input logic [21:0] a, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] old;
        old    = read_word(a);
        mem[a] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endtask

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = 16'd0;
        busy      = 1'b0;
        cnt       = 0;
    end

    always @(posedge VB) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            busy      = 1'b0;
        end else begin
            data_rdy <= 1'b0;
            if (busy) begin
                if (cnt == 0) begin
                    data_rdy  <= 1'b1;
                    data_read <= read_word(cmd_q.addr);
                    busy      = 1'b0;
                end else begin
                    cnt--;
                end
            end
            if (!sdram_ack && !busy && sdram_req) begin
                sdram_ack <= 1'b1;
                busy      = 1'b1;
                cnt       = LAT - 1;
                cmd_q     = sdram_cmd;
                if (!sdram_cmd.rnw) begin
                    write_word(sdram_cmd.addr, sdram_cmd.din, sdram_cmd.wrmask);
                end
            end else if (!sdram_ack && prog_we) begin
                sdram_ack <= 1'b1;
                write_word(prog.addr, {prog.data, prog.data}, prog.mask);
            end else begin
                sdram_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== verif/mem_sva.sv ====
// Arbiter protocol assertions, bound into slot_arbiter

module mem_sva (
    input logic                VB,
    input logic                rst_n,
    input logic                downloading,
    input logic                sdram_req,
    input logic                sdram_ack,
    input logic [3:0]          pending,
    input logic [3:0]          done,
    input mem_pkg::arb_state_e state
);

    req_hold: assert property (@(posedge VB) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    // Completion goes to at most one slot, and only to one that is waiting
    done_onehot: assert property (@(posedge VB) disable iff (!rst_n)
        $onehot0(done) && ((done & ~pending) == 4'b0))
        else $error("done not one-hot or given to a slot that is not pending");

    // Idle with downloading high must stay idle
    no_grant_dl: assert property (@(posedge VB) disable iff (!rst_n)
        state == mem_pkg::ARB_IDLE && downloading |=> state == mem_pkg::ARB_IDLE)
        else $error("grant issued while downloading");

endmodule

bind slot_arbiter mem_sva sva0 (
    .VB          (VB),
    .rst_n       (rst_n),
    .downloading (downloading),
    .sdram_req   (sdram_req),
    .sdram_ack   (sdram_ack),
    .pending     (pending),
    .done        (done),
    .state       (state)
);

// ==== verif/tb_top.sv ====
// Testbench for the game memory top level
// Directed tests on reset, region reads, cache hits, RAM writes,
// contention and ROM download, with a watchdog

module tb_top;

    localparam int LAT             = 3;
    localparam int WAIT_MAX        = (LAT + 6) * mem_pkg::SLOT_N;
    localparam int ACCESS_N        = 40;
    localparam int WATCHDOG_CYCLES = ACCESS_N * WAIT_MAX + 200;

    `include "lfsr.svh"

    logic                VB;
    logic                rst_n;
    mem_pkg::slot_req_t  slot_req [mem_pkg::SLOT_N];
    mem_pkg::slot_rsp_t  slot_rsp [mem_pkg::SLOT_N];
    logic                downloading;
    logic [22:0]         ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    mem_pkg::prog_cmd_t  prog;
    logic                prog_we;
    logic                cfg_we;
    logic                sdram_req;
    mem_pkg::sdram_cmd_t sdram_cmd;
    logic                sdram_ack;
    logic                data_rdy;
    logic [15:0]         data_read;
    logic                refresh_en;

    int                  errors    = 0;
    int                  req_rises = 0;
    logic                req_q     = 1'b0;
    mem_pkg::sdram_cmd_t cmd_log [$];
    logic [15:0]         shadow [logic [21:0]];

    tb_clk #(.PERIOD(20), .RESET_CYCLES(5)) clk0 (.VB(VB), .rst_n(rst_n));

    sdram_model #(.LAT(LAT)) model0 (
        .VB(VB), .rst_n(rst_n), .sdram_req(sdram_req), .sdram_cmd(sdram_cmd),
        .prog_we(prog_we), .prog(prog), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    cps_mem_top dut0 (
        .VB(VB), .rst_n(rst_n), .slot_req(slot_req), .slot_rsp(slot_rsp),
        .downloading(downloading), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .prog(prog), .prog_we(prog_we), .cfg_we(cfg_we),
        .sdram_req(sdram_req), .sdram_cmd(sdram_cmd), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    // Log the command of every new SDRAM request
    always @(posedge VB) begin
        if (sdram_req && !req_q) begin
            req_rises++;
            cmd_log.push_back(sdram_cmd);
        end
        req_q = sdram_req;
    end

    function automatic logic [21:0] region_base(input int slot);
        case (slot)
            0:       return mem_pkg::ROM_OFFSET;
            1:       return mem_pkg::RAM_OFFSET;
            2:       return mem_pkg::GFX_OFFSET;
            default: return mem_pkg::SND_OFFSET;
        endcase
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] d,
                                                input logic [1:0] m);
        return {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endfunction

    function automatic logic [15:0] expect_word(input logic [21:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_word(a);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ok(input int slot, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_MAX) begin
            @(negedge VB);
            seen = slot_rsp[slot].ok;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("Slot %0d never raised ok at %0t", slot, $time);
        end
    endtask

    task automatic read_slot(input int slot, input logic [21:0] addr);
        bit                  seen;
        int                  rises;
        logic [21:0]         full;
        mem_pkg::sdram_cmd_t c;
        full  = region_base(slot) + addr;
        rises = req_rises;
        @(negedge VB);
        slot_req[slot].cs   = 1'b1;
        slot_req[slot].wr   = 1'b0;
        slot_req[slot].addr = addr;
        wait_ok(slot, seen);
        if (seen) begin
            check_val($sformatf("slot_rsp[%0d].data", slot), slot_rsp[slot].data,
                      expect_word(full));
        end
        slot_req[slot].cs = 1'b0;
        @(negedge VB);
        if (req_rises != rises) begin
            c = cmd_log[$];
            check_val("sdram_cmd.addr", c.addr, full);
            check_val("sdram_cmd.rnw", c.rnw, 1);
        end
    endtask

    task automatic write_ram(input logic [21:0] addr, input logic [15:0] din,
                             input logic [1:0] mask);
        bit                  seen;
        int                  rises;
        logic [21:0]         full;
        mem_pkg::sdram_cmd_t c;
        full  = mem_pkg::RAM_OFFSET + addr;
        rises = req_rises;
        @(negedge VB);
        slot_req[1] = '{cs: 1'b1, wr: 1'b1, addr: addr, din: din, wrmask: mask};
        wait_ok(1, seen);
        slot_req[1].cs = 1'b0;
        slot_req[1].wr = 1'b0;
        shadow[full]   = merge_bytes(expect_word(full), din, mask);
        check_val("sdram_req rises", req_rises - rises, 1);
        if (req_rises != rises) begin
            c = cmd_log[$];
            check_val("sdram_cmd.addr", c.addr, full);
            check_val("sdram_cmd.rnw", c.rnw, 0);
            check_val("sdram_cmd.wrmask", c.wrmask, mask);
            check_val("sdram_cmd.din", c.din, din);
        end
        @(negedge VB);
    endtask

    task automatic test_reset();
        check_val("sdram_req", sdram_req, 0);
        check_val("prog_we", prog_we, 0);
        check_val("cfg_we", cfg_we, 0);
        check_val("pending", dut0.pending, 0);
        check_val("refresh_en", refresh_en, 1);
        for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
            check_val($sformatf("slot_rsp[%0d].ok", s), slot_rsp[s].ok, 0);
        end
    endtask

    task automatic test_region_reads();
        int rises;
        for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
            rises = req_rises;
            read_slot(s, 22'h123 + 22'(s));
            check_val("sdram_req rises", req_rises - rises, 1);
        end
    endtask

    task automatic test_cache_hit();
        int rises;
        for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
            rises = req_rises;
            @(negedge VB);
            slot_req[s].cs   = 1'b1;
            slot_req[s].addr = 22'h123 + 22'(s);
            @(negedge VB);
            check_val($sformatf("slot_rsp[%0d].ok", s), slot_rsp[s].ok, 1);
            check_val($sformatf("slot_rsp[%0d].data", s), slot_rsp[s].data,
                      expect_word(region_base(s) + 22'h123 + 22'(s)));
            slot_req[s].cs = 1'b0;
            @(negedge VB);
            check_val("sdram_req rises", req_rises - rises, 0);
        end
    endtask

    task automatic test_ram_write();
        logic [21:0] a;
        for (int m = 0; m < 4; m++) begin
            a = 22'h40 + 22'(2 * m);
            read_slot(1, a);
            write_ram(a, 16'hC3A5 ^ 16'(m * 16'h1111), 2'(m));
            read_slot(1, a);
            read_slot(1, a + 22'd1);
            read_slot(1, a);
        end
    endtask

    // All four slots start in the same cycle
    task automatic test_contention();
        bit                  active [mem_pkg::SLOT_N];
        int                  remaining;
        int                  n;
        int                  base;
        mem_pkg::sdram_cmd_t c;
        base = cmd_log.size();
        @(negedge VB);
        for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
            slot_req[s] = '{cs: 1'b1, wr: 1'b0, addr: 22'h200 + 22'(s),
                            din: 16'd0, wrmask: 2'b11};
            active[s]   = 1'b1;
        end
        remaining = mem_pkg::SLOT_N;
        n         = 0;
        while (remaining > 0 && n < WAIT_MAX * mem_pkg::SLOT_N) begin
            @(negedge VB);
            n++;
            for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
                if (active[s] && slot_rsp[s].ok) begin
                    check_val($sformatf("slot_rsp[%0d].data", s), slot_rsp[s].data,
                              expect_word(region_base(s) + 22'h200 + 22'(s)));
                    slot_req[s].cs = 1'b0;
                    active[s]      = 1'b0;
                    remaining--;
                end
            end
        end
        if (remaining != 0) begin
            errors++;
            $display("Contention test timed out with %0d slots waiting", remaining);
        end
        check_val("sdram_req rises", cmd_log.size() - base, mem_pkg::SLOT_N);
        for (int s = 0; s < mem_pkg::SLOT_N && base + s < cmd_log.size(); s++) begin
            c = cmd_log[base + s];
            check_val("sdram_cmd.addr order", c.addr,
                      region_base(s) + 22'h200 + 22'(s));
        end
        @(negedge VB);
    endtask

    task automatic load_byte(input logic [22:0] addr, input logic [7:0] data);
        int         n;
        logic [1:0] exp_mask;
        // Even byte goes to the low lane, odd byte to the high lane
        exp_mask = addr[0] ? 2'b01 : 2'b10;
        @(negedge VB);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge VB);
        ioctl_wr = 1'b0;
        check_val("prog.data", prog.data, data);
        if (addr >= mem_pkg::CFG_START) begin
            check_val("cfg_we", cfg_we, 1);
            check_val("prog_we", prog_we, 0);
            @(negedge VB);
            check_val("cfg_we", cfg_we, 0);
        end else begin
            check_val("prog_we", prog_we, 1);
            check_val("cfg_we", cfg_we, 0);
            check_val("prog.addr", prog.addr, addr[22:1]);
            check_val("prog.mask", prog.mask, exp_mask);
            shadow[addr[22:1]] = merge_bytes(expect_word(addr[22:1]), {data, data}, exp_mask);
            n = 0;
            while (prog_we && n < WAIT_MAX) begin
                @(negedge VB);
                n++;
            end
            if (prog_we) begin
                errors++;
                $display("prog_we never released at %0t", $time);
            end
        end
    endtask

    task automatic test_download();
        bit seen;
        int rises;
        rises = req_rises;
        @(negedge VB);
        downloading = 1'b1;
        @(negedge VB);
        slot_req[2] = '{cs: 1'b1, wr: 1'b0, addr: 22'h321, din: 16'd0, wrmask: 2'b11};
        repeat (8) begin
            @(negedge VB);
            check_val("sdram_req", sdram_req, 0);
            check_val("slot_rsp[2].ok", slot_rsp[2].ok, 0);
        end
        check_val("pending[2]", dut0.pending[2], 1);
        check_val("refresh_en", refresh_en, 0);
        load_byte(23'h000101, 8'hA5);
        load_byte(23'h000102, 8'h3C);
        load_byte(mem_pkg::CFG_START + 23'd5, 8'h77);
        check_val("sdram_req rises", req_rises - rises, 0);
        downloading = 1'b0;
        wait_ok(2, seen);
        if (seen) begin
            check_val("slot_rsp[2].data", slot_rsp[2].data,
                      expect_word(mem_pkg::GFX_OFFSET + 22'h321));
        end
        slot_req[2].cs = 1'b0;
        @(negedge VB);
    endtask

    initial begin
        for (int s = 0; s < mem_pkg::SLOT_N; s++) begin
            slot_req[s] = '0;
        end
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        @(posedge rst_n);
        @(negedge VB);
        test_reset();
        test_region_reads();
        test_cache_hit();
        test_ram_write();
        test_contention();
        test_download();
        $display("tb_top finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge VB);
        $display("Watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
verilog/mem_pkg.sv
verilog/slot_port.sv
verilog/slot_arbiter.sv
verilog/rom_loader.sv
verilog/cps_mem_top.sv
verif/tb_clk.sv
verif/sdram_model.sv
verif/mem_sva.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
